// File: hw/tscPkg.sv
package tscPkg;

	localparam int WordSize = 16; // one address per 16-bit word.
	localparam int ImmSize = 8;
	localparam int TargetSize = 12;
	localparam int RegCount = 4;

	typedef logic [WordSize-1:0] word_t;
	typedef logic [$clog2(RegCount)-1:0] regIdx_t;

	// the low two bits of the branch opcodes double as the branch kind.
	typedef enum logic [3:0] {
		OpBne = 4'd0,
		OpBeq = 4'd1,
		OpBgz = 4'd2,
		OpBlz = 4'd3,
		OpAdi = 4'd4,
		OpOri = 4'd5,
		OpLhi = 4'd6,
		OpLwd = 4'd7,
		OpSwd = 4'd8,
		OpJmp = 4'd9,
		OpJal = 4'd10,
		OpRtype = 4'd15
	} opcode_t;

	typedef enum logic [5:0] {
		FnAdd = 6'd0,
		FnSub = 6'd1,
		FnAnd = 6'd2,
		FnOrr = 6'd3,
		FnNot = 6'd4,
		FnTcp = 6'd5,
		FnShl = 6'd6,
		FnShr = 6'd7,
		FnJpr = 6'd25,
		FnJrl = 6'd26,
		FnWwd = 6'd28,
		FnHlt = 6'd29
	} func_t;

	// same order as the first eight function codes.
	typedef enum logic [2:0] {
		AluAdd, AluSub, AluAnd, AluOr, AluNot, AluTcp, AluShl, AluShr
	} aluOp_t;

	typedef enum logic [1:0] {
		ImmSign, ImmZero, ImmHigh
	} immSel_t;

	typedef enum logic [1:0] {
		PcSeq, PcBranch, PcJump, PcReg
	} pcSel_t;

	typedef struct packed {
		aluOp_t aluOp;
		logic aluSrcImm;
		immSel_t immSel;
		logic regWrite;
		logic writeLink; // PC+1 goes to register 2.
		logic memRead;
		logic memWrite;
		pcSel_t pcSel;
		logic [1:0] branchKind;
		logic outWrite;
		logic halt;
	} ctrl_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		word_t adr;
		word_t dat;
	} wbReq_t;

	typedef struct packed {
		logic ack;
		word_t dat;
	} wbRsp_t;

endpackage

// File: hw/tscDecoder.sv
`timescale 1ns/1ps

module tscDecoder (
	input tscPkg::word_t instr,
	output tscPkg::ctrl_t ctrl
);

	tscPkg::opcode_t opcode;
	tscPkg::func_t func;

	assign opcode = tscPkg::opcode_t'(instr[15:12]);
	assign func = tscPkg::func_t'(instr[5:0]);

	always_comb begin
		// anything not listed falls through as a no-op that still retires.
		ctrl = '0;
		ctrl.aluOp = tscPkg::AluAdd;
		ctrl.immSel = tscPkg::ImmSign;
		ctrl.pcSel = tscPkg::PcSeq;
		case (opcode)
			tscPkg::OpBne, tscPkg::OpBeq, tscPkg::OpBgz, tscPkg::OpBlz: begin
				ctrl.pcSel = tscPkg::PcBranch;
				ctrl.branchKind = instr[13:12];
			end
			tscPkg::OpAdi, tscPkg::OpOri, tscPkg::OpLhi, tscPkg::OpLwd: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.memRead = (opcode == tscPkg::OpLwd);
				if (opcode == tscPkg::OpOri) begin
					ctrl.aluOp = tscPkg::AluOr;
					ctrl.immSel = tscPkg::ImmZero;
				end else if (opcode == tscPkg::OpLhi) begin
					ctrl.aluOp = tscPkg::AluOr;
					ctrl.immSel = tscPkg::ImmHigh;
				end
			end
			tscPkg::OpSwd: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			tscPkg::OpJmp, tscPkg::OpJal: begin
				ctrl.pcSel = tscPkg::PcJump;
				ctrl.regWrite = (opcode == tscPkg::OpJal);
				ctrl.writeLink = (opcode == tscPkg::OpJal);
			end
			tscPkg::OpRtype: begin
				case (func)
					tscPkg::FnAdd, tscPkg::FnSub, tscPkg::FnAnd, tscPkg::FnOrr,
					tscPkg::FnNot, tscPkg::FnTcp, tscPkg::FnShl, tscPkg::FnShr: begin
						ctrl.aluOp = tscPkg::aluOp_t'(instr[2:0]); // codes line up with aluOp_t.
						ctrl.regWrite = 1'b1;
					end
					tscPkg::FnJpr: ctrl.pcSel = tscPkg::PcReg;
					tscPkg::FnJrl: begin
						ctrl.pcSel = tscPkg::PcReg;
						ctrl.regWrite = 1'b1;
						ctrl.writeLink = 1'b1;
					end
					tscPkg::FnWwd: ctrl.outWrite = 1'b1;
					tscPkg::FnHlt: ctrl.halt = 1'b1;
					default: ;
				endcase
			end
			default: ;
		endcase
	end

endmodule

// File: hw/tscRegFile.sv
`timescale 1ns/1ps

module tscRegFile (
	input logic clk,
	input logic rst,
	input tscPkg::regIdx_t rdAddr1,
	input tscPkg::regIdx_t rdAddr2,
	output tscPkg::word_t rdData1,
	output tscPkg::word_t rdData2,
	input logic wrEn,
	input tscPkg::regIdx_t wrAddr,
	input tscPkg::word_t wrData
);

	tscPkg::word_t regs [tscPkg::RegCount];

	// reads see a write only after the edge that performs it.
	assign rdData1 = regs[rdAddr1];
	assign rdData2 = regs[rdAddr2];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < tscPkg::RegCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

endmodule

// File: hw/tscAlu.sv
`timescale 1ns/1ps

module tscAlu (
	input tscPkg::ctrl_t ctrl,
	input tscPkg::word_t rsVal,
	input tscPkg::word_t rtVal,
	input logic [tscPkg::ImmSize-1:0] imm,
	output tscPkg::word_t result,
	output logic branchTaken
);

	localparam int ExtBits = tscPkg::WordSize - tscPkg::ImmSize;

	tscPkg::word_t immVal;
	tscPkg::word_t opA;
	tscPkg::word_t opB;

	always_comb begin
		case (ctrl.immSel)
			tscPkg::ImmSign: immVal = {{ExtBits{imm[tscPkg::ImmSize-1]}}, imm};
			tscPkg::ImmHigh: immVal = {imm, {ExtBits{1'b0}}};
			default: immVal = {{ExtBits{1'b0}}, imm};
		endcase
	end

	// LHI ignores rs, so the OR sees zero on that side.
	assign opA = (ctrl.aluSrcImm && ctrl.immSel == tscPkg::ImmHigh) ? '0 : rsVal;
	assign opB = ctrl.aluSrcImm ? immVal : rtVal;

	always_comb begin
		case (ctrl.aluOp)
			tscPkg::AluAdd: result = opA + opB;
			tscPkg::AluSub: result = opA - opB;
			tscPkg::AluAnd: result = opA & opB;
			tscPkg::AluOr: result = opA | opB;
			tscPkg::AluNot: result = ~opA;
			tscPkg::AluTcp: result = ~opA + 1'b1;
			tscPkg::AluShl: result = {opA[tscPkg::WordSize-2:0], 1'b0};
			default: result = {opA[tscPkg::WordSize-1], opA[tscPkg::WordSize-1:1]}; // arithmetic.
		endcase
	end

	always_comb begin
		case (ctrl.branchKind)
			2'd0: branchTaken = (rsVal != rtVal);
			2'd1: branchTaken = (rsVal == rtVal);
			2'd2: branchTaken = ($signed(rsVal) > 0);
			default: branchTaken = rsVal[tscPkg::WordSize-1];
		endcase
	end

endmodule

// File: hw/tscPcUnit.sv
`timescale 1ns/1ps

module tscPcUnit (
	input logic clk,
	input logic rst,
	input logic commit,
	input tscPkg::ctrl_t ctrl,
	input logic branchTaken,
	input logic [tscPkg::ImmSize-1:0] imm,
	input logic [tscPkg::TargetSize-1:0] target,
	input tscPkg::word_t rsVal,
	output tscPkg::word_t pc,
	output tscPkg::word_t pcPlusOne
);

	tscPkg::word_t offset;
	tscPkg::word_t nextPc;

	assign pcPlusOne = pc + 1'b1; // also the link value for JAL and JRL.
	assign offset = {{(tscPkg::WordSize - tscPkg::ImmSize){imm[tscPkg::ImmSize-1]}}, imm};

	always_comb begin
		case (ctrl.pcSel)
			tscPkg::PcBranch: nextPc = branchTaken ? pcPlusOne + offset : pcPlusOne;
			tscPkg::PcJump: nextPc = {pc[tscPkg::WordSize-1:tscPkg::TargetSize], target};
			tscPkg::PcReg: nextPc = rsVal;
			default: nextPc = pcPlusOne;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (commit) begin
			pc <= nextPc;
		end
	end

endmodule

// File: hw/tscSequencer.sv
`timescale 1ns/1ps

module tscSequencer (
	input logic clk,
	input logic rst,
	input tscPkg::ctrl_t ctrl,
	input tscPkg::word_t pc,
	input tscPkg::word_t dataAdr,
	input tscPkg::word_t storeData,
	input tscPkg::word_t rsVal,
	output tscPkg::wbReq_t wbReq,
	input tscPkg::wbRsp_t wbRsp,
	output tscPkg::word_t instr,
	output tscPkg::word_t loadData,
	output logic commit,
	output logic outValid,
	output tscPkg::word_t outData,
	output logic halted
);

	typedef enum logic [1:0] {
		Fetch, Exec, Data, Stop
	} step_t;

	step_t state;
	logic memAccess;

	assign memAccess = ctrl.memRead | ctrl.memWrite;

	// the slave drives read data during its ack, which is the retiring cycle of a load.
	assign loadData = wbRsp.dat;

	assign commit = (state == Exec && !memAccess && !ctrl.halt) ||
		(state == Data && wbRsp.ack);

	// high from the EXEC cycle of HLT onward.
	assign halted = (state == Stop) || (state == Exec && ctrl.halt);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= Fetch;
			wbReq.cyc <= 1'b0;
			wbReq.stb <= 1'b0;
			wbReq.we <= 1'b0;
		end else begin
			case (state)
				Fetch: begin
					if (!wbReq.cyc) begin
						wbReq.cyc <= 1'b1;
						wbReq.stb <= 1'b1;
						wbReq.we <= 1'b0;
						wbReq.adr <= pc;
					end else if (wbRsp.ack) begin
						wbReq.cyc <= 1'b0;
						wbReq.stb <= 1'b0;
						instr <= wbRsp.dat;
						state <= Exec;
					end
				end
				Exec: begin
					if (memAccess) begin
						wbReq.cyc <= 1'b1;
						wbReq.stb <= 1'b1;
						wbReq.we <= ctrl.memWrite;
						wbReq.adr <= dataAdr;
						wbReq.dat <= storeData;
						state <= Data;
					end else if (ctrl.halt) begin
						state <= Stop;
					end else begin
						state <= Fetch;
					end
				end
				Data: begin
					if (wbRsp.ack) begin
						wbReq.cyc <= 1'b0;
						wbReq.stb <= 1'b0;
						wbReq.we <= 1'b0;
						state <= Fetch;
					end
				end
				default: ; // stays here until reset.
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else begin
			outValid <= commit && ctrl.outWrite;
		end
		if (commit && ctrl.outWrite) begin
			outData <= rsVal;
		end
	end

endmodule

// File: hw/tscCpu.sv
`timescale 1ns/1ps

module tscCpu (
	input logic clk,
	input logic rst,
	output tscPkg::wbReq_t wbReq,
	input tscPkg::wbRsp_t wbRsp,
	output logic outValid,
	output tscPkg::word_t outData,
	output logic halted
);

	localparam tscPkg::regIdx_t LinkReg = 2'd2;

	tscPkg::word_t instr;
	tscPkg::ctrl_t ctrl;
	tscPkg::word_t pc;
	tscPkg::word_t pcPlusOne;
	tscPkg::word_t rsVal;
	tscPkg::word_t rtVal;
	tscPkg::word_t aluResult;
	tscPkg::word_t loadData;
	tscPkg::word_t wrData;
	tscPkg::regIdx_t wrAddr;
	logic branchTaken;
	logic commit;
	logic isRtype;

	assign isRtype = (instr[15:12] == tscPkg::OpRtype);

	// rd for R-type, rt for I-type, and register 2 for the link.
	assign wrAddr = ctrl.writeLink ? LinkReg : (isRtype ? instr[7:6] : instr[9:8]);
	assign wrData = ctrl.writeLink ? pcPlusOne : (ctrl.memRead ? loadData : aluResult);

	tscSequencer sequencer (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl),
		.pc(pc),
		.dataAdr(aluResult),
		.storeData(rtVal),
		.rsVal(rsVal),
		.wbReq(wbReq),
		.wbRsp(wbRsp),
		.instr(instr),
		.loadData(loadData),
		.commit(commit),
		.outValid(outValid),
		.outData(outData),
		.halted(halted)
	);

	tscDecoder decoder (.instr(instr), .ctrl(ctrl));

	tscRegFile regFile (
		.clk(clk),
		.rst(rst),
		.rdAddr1(instr[11:10]),
		.rdAddr2(instr[9:8]),
		.rdData1(rsVal),
		.rdData2(rtVal),
		.wrEn(commit && ctrl.regWrite),
		.wrAddr(wrAddr),
		.wrData(wrData)
	);

	tscAlu alu (
		.ctrl(ctrl),
		.rsVal(rsVal),
		.rtVal(rtVal),
		.imm(instr[7:0]),
		.result(aluResult),
		.branchTaken(branchTaken)
	);

	tscPcUnit pcUnit (
		.clk(clk),
		.rst(rst),
		.commit(commit),
		.ctrl(ctrl),
		.branchTaken(branchTaken),
		.imm(instr[7:0]),
		.target(instr[11:0]),
		.rsVal(rsVal),
		.pc(pc),
		.pcPlusOne(pcPlusOne)
	);

endmodule

// File: dv/tscCpuProperties.sv
`timescale 1ns/1ps

module tscCpuProperties (
	input logic clk,
	input logic rst,
	input tscPkg::wbReq_t wbReq,
	input tscPkg::wbRsp_t wbRsp,
	input logic outValid,
	input logic halted
);

	// the master drives strobe and cycle as one signal.
	stbMatchesCyc: assert property (@(posedge clk) disable iff (rst)
		wbReq.stb == wbReq.cyc)
		else $error("stb differs from cyc");

	// a waiting request keeps address, direction and data.
	requestHeld: assert property (@(posedge clk) disable iff (rst)
		wbReq.stb && !wbRsp.ack |=>
			$stable(wbReq.adr) && $stable(wbReq.we) && $stable(wbReq.dat))
		else $error("request changed before its ack");

	dropAfterAck: assert property (@(posedge clk) disable iff (rst)
		wbReq.stb && wbRsp.ack |=> !wbReq.stb)
		else $error("stb still high in the cycle after ack");

	singleOutPulse: assert property (@(posedge clk) disable iff (rst)
		outValid |=> !outValid)
		else $error("outValid high for two cycles in a row");

	quietWhenHalted: assert property (@(posedge clk) disable iff (rst)
		halted |-> !wbReq.cyc)
		else $error("bus request while halted");

endmodule

bind tscCpu tscCpuProperties props (
	.clk(clk),
	.rst(rst),
	.wbReq(wbReq),
	.wbRsp(wbRsp),
	.outValid(outValid),
	.halted(halted)
);

// File: dv/tscCpuTb.sv
`timescale 1ns/1ps

module tscCpuTb;

	localparam int ProgLen = 60;
	localparam int OutCount = 21;
	localparam int MemWords = 256;
	localparam int HaltTimeout = 2000; // cycles.
	localparam int RequestTimeout = 20;

	// the test program, four words per line from address 0.
	localparam logic [15:0] Program [ProgLen] = '{
		16'h6112, 16'h5534, 16'hf41c, 16'h42fd, // r1 = 0x1234 and r2 = -3.
		16'hf6c0, 16'hfc1c, 16'hf6c1, 16'hfc1c,
		16'hf6c2, 16'hfc1c, 16'hf6c3, 16'hfc1c,
		16'hf4c4, 16'hfc1c, 16'hf4c5, 16'hfc1c,
		16'hf4c6, 16'hfc1c, 16'hf8c7, 16'hfc1c, // shr of a negative value.
		16'h4040, 16'h8102, 16'h82ff, 16'h7302, // stores around r0 = 0x40, then a load.
		16'hfc1c, 16'h0701, 16'hf01c, 16'h1701,
		16'hf81c, 16'h1101, 16'hf81c, 16'h0101,
		16'hf41c, 16'h2801, 16'hf01c, 16'h2001,
		16'hf81c, 16'h3001, 16'hf41c, 16'h3801,
		16'hfc1c, 16'h40c3, 16'hf01c, 16'h40ff, // the loop counts r0 down from 3.
		16'h20fd, 16'hf01c, 16'h9030, 16'hf41c,
		16'ha034, 16'hf81c, 16'h4338, 16'hfc1a, // JAL links 49 and JRL links 52.
		16'hf81c, 16'hf819, 16'hf41c, 16'hf41c,
		16'hf81c, 16'h8250, 16'hf01d, 16'hf41c
	};

	// WWD values on the correct path, in order.
	localparam logic [15:0] Expected [OutCount] = '{
		16'h1234, 16'h1231, 16'h1237, 16'h1234, 16'hfffd, 16'hedcb, 16'hedcc,
		16'h2468, 16'hfffe, 16'h1234, 16'h0040, 16'hfffd, 16'h0040, 16'h1234,
		16'h0003, 16'h0002, 16'h0001, 16'h0000, 16'h0031, 16'h0031, 16'h0034
	};

	logic clk;
	logic rst = 1'b1;
	tscPkg::wbReq_t wbReq;
	tscPkg::wbRsp_t wbRsp = '0;
	logic outValid;
	tscPkg::word_t outData;
	logic halted;

	tscPkg::word_t mem [MemWords];
	int waitLeft = 0;
	logic busy = 1'b0;
	int outIdx = 0;
	logic passed = 1'b0;
	logic failReported = 1'b0;

	tscCpu uut (
		.clk(clk),
		.rst(rst),
		.wbReq(wbReq),
		.wbRsp(wbRsp),
		.outValid(outValid),
		.outData(outData),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic stopWithError(input string msg);
		failReported = 1'b1;
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped on a failed check");
	endtask

	// memory with 0 to 3 wait states before each ack.
	always @(posedge clk) begin
		#2;
		if (rst || wbRsp.ack) begin
			wbRsp.ack = 1'b0;
			busy = 1'b0;
		end else if (wbReq.stb) begin
			if (!busy) begin
				busy = 1'b1;
				waitLeft = $urandom % 4;
			end
			if (waitLeft == 0) begin
				wbRsp.ack = 1'b1;
				if (wbReq.we) begin
					mem[wbReq.adr[7:0]] = wbReq.dat;
				end else begin
					wbRsp.dat = mem[wbReq.adr[7:0]];
				end
			end else begin
				waitLeft--;
			end
		end
	end

	always @(posedge clk) begin
		#2;
		if (!rst && outValid) begin
			assert (!halted) else stopWithError("outValid pulsed while the core was halted");
			if (outIdx < OutCount) begin
				assert (outData == Expected[outIdx]) else stopWithError($sformatf(
					"ERR %0t: output %0d is %h, expected %h",
					$time, outIdx, outData, Expected[outIdx]));
				outIdx++;
			end else begin
				stopWithError($sformatf("ERR %0t: more WWD outputs than expected", $time));
			end
		end
	end

	initial begin
		int cycles;
		void'($urandom(32'h832b_9717));
		for (int a = 0; a < MemWords; a++) begin
			mem[a] = (a < ProgLen) ? Program[a] : '0;
		end
		repeat (10) begin
			@(posedge clk);
			#2;
			assert (!wbReq.cyc && !outValid && !halted) else stopWithError($sformatf(
				"ERR %0t: cyc, outValid or halted high during reset", $time));
		end
		rst = 1'b0;
		cycles = 0;
		while (!wbReq.cyc && cycles < RequestTimeout) begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (!wbReq.cyc) begin
			stopWithError("no bus request was issued after reset");
		end
		assert (wbReq.adr == '0 && !wbReq.we) else stopWithError($sformatf(
			"ERR %0t: first request is not a read at address 0", $time));
		cycles = 0;
		while (!halted && cycles < HaltTimeout) begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (!halted) begin
			stopWithError("the core did not halt before the timeout");
		end
		repeat (5) @(posedge clk); // the monitor keeps watching outValid here.
		assert (outIdx == OutCount) else stopWithError($sformatf(
			"ERR %0t: %0d WWD outputs seen, expected %0d", $time, outIdx, OutCount));
		if (mem[8'h42] == 16'h1234 && mem[8'h3f] == 16'hfffd && mem[8'h50] == 16'h0034) begin
			passed = 1'b1;
			$display("=== PASS ===");
			$finish;
		end else begin
			stopWithError($sformatf("ERR %0t: memory at 0x3f 0x42 0x50 holds %h %h %h",
				$time, mem[8'h3f], mem[8'h42], mem[8'h50]));
		end
	end

	final begin
		if (!passed && !failReported) begin
			$display("=== FAIL ===");
		end
	end

endmodule

// File: tscCpu.f
hw/tscPkg.sv
hw/tscDecoder.sv
hw/tscRegFile.sv
hw/tscAlu.sv
hw/tscPcUnit.sv
hw/tscSequencer.sv
hw/tscCpu.sv
dv/tscCpuProperties.sv
dv/tscCpuTb.sv

// File: run.sh
#!/bin/sh
# Builds the CPU testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tscCpuTb \
	--Mdir obj_dir \
	-o tscCpuSim \
	-f tscCpu.f

./obj_dir/tscCpuSim | tee sim.log

if grep -q "^=== PASS ===$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
